// File: logic/uart_cmd_cfg.svh
`ifndef UART_CMD_CFG_SVH
`define UART_CMD_CFG_SVH

// clock cycles per serial bit, short for simulation
`define UART_CLKS_PER_BIT 16

// start, eight data, parity, stop
`define UART_FRAME_BITS 11

// 0 forces parity_err low
`define UART_PARITY_CHECK 1

// bit period counter, holds 0 to UART_CLKS_PER_BIT-1
`define UART_BIT_CNT_W 5

// frame bit index, holds 0 to UART_FRAME_BITS-1
`define UART_FRAME_CNT_W 4

`endif

// File: logic/uart_cmd_pkg.sv
package uart_cmd_pkg;

  // payload of one serial frame
  typedef logic [7:0] frame_byte_t;

  // command word seen as fields
  typedef struct packed {
    logic        rw;
    logic [6:0]  addr;
    frame_byte_t data;
  } cmd_fields_t;

  // same word seen as the two frame payloads
  typedef struct packed {
    frame_byte_t hi_byte;
    frame_byte_t lo_byte;
  } cmd_bytes_t;

  // rw = 1 is a read
  typedef union packed {
    cmd_fields_t fields;
    cmd_bytes_t  bytes;
  } cmd_word_u;

  // reply byte and its parity check
  typedef struct packed {
    frame_byte_t data;
    logic        parity_err;
  } rd_result_t;

endpackage

// File: logic/baud_tick_gen.sv
`timescale 1ns/1ns
`include "uart_cmd_cfg.svh"

module baud_tick_gen (
  input  logic clk,
  input  logic rst_n,
  input  logic run,
  input  logic restart,
  output logic bit_tick,
  output logic mid_tick
);

  logic [`UART_BIT_CNT_W-1:0] cnt;
  logic                       cnt_last;
  logic                       cnt_mid;

  assign cnt_last = (cnt == `UART_BIT_CNT_W'(`UART_CLKS_PER_BIT - 1));
  assign cnt_mid  = (cnt == `UART_BIT_CNT_W'(`UART_CLKS_PER_BIT / 2 - 1));

  // restart wins so a new frame always begins on a clean bit grid
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cnt <= '0;
    end else if (restart) begin
      cnt <= '0;
    end else if (run) begin
      if (cnt_last) begin
        cnt <= '0;
      end else begin
        cnt <= cnt + 1'b1;
      end
    end
  end

  // ticks only while running
  assign bit_tick = run && cnt_last;
  assign mid_tick = run && cnt_mid;

endmodule

// File: logic/uart_tx_frame.sv
`timescale 1ns/1ns
`include "uart_cmd_cfg.svh"

module uart_tx_frame
  import uart_cmd_pkg::*;
(
  input  logic        clk,
  input  logic        rst_n,
  input  frame_byte_t tx_byte,
  input  logic        tx_start,
  output logic        tx,
  output logic        tx_busy,
  output logic        tx_done
);

  logic [`UART_FRAME_BITS-1:0]  shift_q;
  logic [`UART_FRAME_CNT_W-1:0] bit_idx;
  logic                         bit_tick;
  logic                         parity_bit;
  logic                         last_bit;

  // odd parity over the payload
  assign parity_bit = ~^tx_byte;

  assign last_bit = bit_tick && (bit_idx == `UART_FRAME_CNT_W'(`UART_FRAME_BITS - 1));

  baud_tick_gen baud_tick_gen_inst (
    .clk      (clk),
    .rst_n    (rst_n),
    .run      (tx_busy),
    .restart  (tx_start),
    .bit_tick (bit_tick),
    .mid_tick ()
  );

  // frame goes out from bit 0, so the stop bit sits at the top
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      shift_q <= '1;
    end else if (tx_start) begin
      shift_q <= {1'b1, parity_bit, tx_byte, 1'b0};
    end else if (bit_tick) begin
      shift_q <= {1'b1, shift_q[`UART_FRAME_BITS-1:1]};
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      bit_idx <= '0;
    end else if (tx_start) begin
      bit_idx <= '0;
    end else if (bit_tick) begin
      bit_idx <= bit_idx + 1'b1;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      tx_busy <= 1'b0;
    end else if (tx_start) begin
      tx_busy <= 1'b1;
    end else if (last_bit) begin
      tx_busy <= 1'b0;
    end
  end

  // all ones after the last shift, so the line idles high
  assign tx      = shift_q[0];
  assign tx_done = last_bit;

endmodule

// File: logic/uart_rx_frame.sv
`timescale 1ns/1ns
`include "uart_cmd_cfg.svh"

module uart_rx_frame
  import uart_cmd_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n,
  input  logic       rx,
  input  logic       rx_arm,
  output rd_result_t rx_result,
  output logic       rx_valid
);

  logic [2:0]                   rx_sync;
  logic                         rx_bit;
  logic                         rx_fall;
  logic                         start_det;
  logic                         busy;
  logic [`UART_FRAME_CNT_W-1:0] bit_idx;
  logic                         mid_tick;
  logic                         is_start;
  logic                         is_data;
  logic                         is_par;
  logic                         is_stop;
  frame_byte_t                  data_sh;
  logic                         par_q;
  logic                         par_bad;

  // two flops for metastability, the third for the edge
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rx_sync <= '1;
    end else begin
      rx_sync <= {rx_sync[1:0], rx};
    end
  end

  assign rx_bit    = rx_sync[1];
  assign rx_fall   = rx_sync[2] && !rx_sync[1];
  assign start_det = rx_arm && !busy && rx_fall;

  baud_tick_gen baud_tick_gen_inst (
    .clk      (clk),
    .rst_n    (rst_n),
    .run      (busy),
    .restart  (start_det),
    .bit_tick (),
    .mid_tick (mid_tick)
  );

  assign is_start = (bit_idx == '0);
  assign is_par   = (bit_idx == `UART_FRAME_CNT_W'(`UART_FRAME_BITS - 2));
  assign is_stop  = (bit_idx == `UART_FRAME_CNT_W'(`UART_FRAME_BITS - 1));
  assign is_data  = !is_start && (bit_idx < `UART_FRAME_CNT_W'(`UART_FRAME_BITS - 2));

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      busy     <= 1'b0;
      bit_idx  <= '0;
      rx_valid <= 1'b0;
    end else begin
      rx_valid <= 1'b0;
      if (start_det) begin
        busy    <= 1'b1;
        bit_idx <= '0;
      end else if (mid_tick) begin
        bit_idx <= bit_idx + 1'b1;
        // glitch on the line, not a real start bit
        if (is_start && rx_bit) begin
          busy <= 1'b0;
        end
        if (is_stop) begin
          busy     <= 1'b0;
          rx_valid <= 1'b1;
        end
      end
    end
  end

  // odd parity means the xor over data and parity is one
  assign par_bad = (`UART_PARITY_CHECK != 0) && !(^{data_sh, par_q});

  // lsb arrives first
  always_ff @(posedge clk) begin
    if (mid_tick) begin
      if (is_data) begin
        data_sh <= {rx_bit, data_sh[7:1]};
      end
      if (is_par) begin
        par_q <= rx_bit;
      end
      if (is_stop) begin
        rx_result.data       <= data_sh;
        rx_result.parity_err <= par_bad;
      end
    end
  end

endmodule

// File: logic/uart_cmd_ctrl.sv
`timescale 1ns/1ns

module uart_cmd_ctrl
  import uart_cmd_pkg::*;
(
  input  logic        clk,
  input  logic        rst_n,
  input  cmd_word_u   cmd_in,
  input  logic        cmd_vld,
  output logic        cmd_rdy,
  output frame_byte_t tx_byte,
  output logic        tx_start,
  input  logic        tx_done,
  output logic        rx_arm,
  input  logic        rx_valid,
  input  rd_result_t  rx_result,
  output rd_result_t  read_data,
  output logic        read_rdy
);

  enum logic [2:0] {
    st_idle,
    st_send_hdr,
    st_send_data,
    st_wait_reply,
    st_done
  } state;

  cmd_word_u cmd_q;
  logic      accept;

  // done is a ready state too, it only adds the read strobe
  assign cmd_rdy  = (state == st_idle) || (state == st_done);
  assign accept   = cmd_vld && cmd_rdy;
  assign read_rdy = (state == st_done);
  assign rx_arm   = (state == st_wait_reply);

  // header first, data byte only in its own state
  assign tx_byte = (state == st_send_data) ? cmd_q.bytes.lo_byte : cmd_q.bytes.hi_byte;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state    <= st_idle;
      tx_start <= 1'b0;
    end else begin
      tx_start <= 1'b0;
      case (state)
        st_idle, st_done: begin
          if (accept) begin
            state    <= st_send_hdr;
            tx_start <= 1'b1;
          end else begin
            state <= st_idle;
          end
        end
        st_send_hdr: begin
          if (tx_done) begin
            if (cmd_q.fields.rw) begin
              state <= st_wait_reply;
            end else begin
              state    <= st_send_data;
              tx_start <= 1'b1;
            end
          end
        end
        st_send_data: begin
          if (tx_done) begin
            state <= st_idle;
          end
        end
        st_wait_reply: begin
          // no timeout, a silent far end keeps us here
          if (rx_valid) begin
            state <= st_done;
          end
        end
        default: begin
          state <= st_idle;
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      cmd_q <= cmd_in;
    end
    if (rx_valid) begin
      read_data <= rx_result;
    end
  end

endmodule

// File: logic/uart_cmd_top.sv
`timescale 1ns/1ns

module uart_cmd_top
  import uart_cmd_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n,
  input  cmd_word_u  cmd_in,
  input  logic       cmd_vld,
  output logic       cmd_rdy,
  input  logic       rx,
  output logic       tx,
  output rd_result_t read_data,
  output logic       read_rdy
);

  frame_byte_t tx_byte;
  logic        tx_start;
  logic        tx_done;
  logic        rx_arm;
  logic        rx_valid;
  rd_result_t  rx_result;

  uart_cmd_ctrl uart_cmd_ctrl_inst (
    .clk       (clk),
    .rst_n     (rst_n),
    .cmd_in    (cmd_in),
    .cmd_vld   (cmd_vld),
    .cmd_rdy   (cmd_rdy),
    .tx_byte   (tx_byte),
    .tx_start  (tx_start),
    .tx_done   (tx_done),
    .rx_arm    (rx_arm),
    .rx_valid  (rx_valid),
    .rx_result (rx_result),
    .read_data (read_data),
    .read_rdy  (read_rdy)
  );

  // the sequencer tracks its own state, so busy is not needed here
  uart_tx_frame uart_tx_frame_inst (
    .clk      (clk),
    .rst_n    (rst_n),
    .tx_byte  (tx_byte),
    .tx_start (tx_start),
    .tx       (tx),
    .tx_busy  (),
    .tx_done  (tx_done)
  );

  uart_rx_frame uart_rx_frame_inst (
    .clk       (clk),
    .rst_n     (rst_n),
    .rx        (rx),
    .rx_arm    (rx_arm),
    .rx_result (rx_result),
    .rx_valid  (rx_valid)
  );

endmodule

// File: verif/uart_slave_model.sv
`timescale 1ns/1ns
`include "uart_cmd_cfg.svh"

module uart_slave_model
  import uart_cmd_pkg::*;
(
  input  logic        clk,
  input  logic        rst_n,
  input  logic        rx,
  output logic        tx,
  input  logic        inject_bad_parity,
  output logic        frame_seen,
  output frame_byte_t frame_byte,
  output logic        frame_ok,
  output int          frame_cnt
);

  frame_byte_t regs [128];
  integer      seed;

  // samples near mid-bit on falling clock edges
  task automatic read_frame(output frame_byte_t b, output logic ok);
    logic [`UART_FRAME_BITS-1:0] bits;
    do @(negedge clk); while (rx !== 1'b0);
    repeat (`UART_CLKS_PER_BIT / 2 - 1) @(negedge clk);
    bits = {rx, {(`UART_FRAME_BITS - 1){1'b0}}};
    repeat (`UART_FRAME_BITS - 1) begin
      repeat (`UART_CLKS_PER_BIT) @(negedge clk);
      bits = {rx, bits[`UART_FRAME_BITS-1:1]};
    end
    b = bits[8:1];
    // start low, stop high, odd parity over data and parity bit
    ok = !bits[0] && bits[10] && (^bits[9:1]);
  endtask

  task automatic send_frame(input frame_byte_t b, input logic bad_par);
    logic [`UART_FRAME_BITS-1:0] bits;
    bits = {1'b1, (~^b) ^ bad_par, b, 1'b0};
    repeat (`UART_FRAME_BITS) begin
      @(posedge clk);
      tx <= bits[0];
      bits = {1'b1, bits[`UART_FRAME_BITS-1:1]};
      repeat (`UART_CLKS_PER_BIT - 1) @(posedge clk);
    end
  endtask

  initial begin
    frame_byte_t b;
    logic        ok;
    logic        wr_next;
    logic [6:0]  wr_addr;
    int          delay_bits;
    seed       = 32'h38b6;
    wr_next    = 1'b0;
    wr_addr    = '0;
    tx         <= 1'b1;
    frame_seen <= 1'b0;
    frame_byte <= '0;
    frame_ok   <= 1'b0;
    frame_cnt  <= 0;
    for (int i = 0; i < 128; i++) begin
      regs[7'(i)] = 8'(i * 37) ^ 8'h5a;
    end
    wait (rst_n === 1'b1);
    forever begin
      read_frame(b, ok);
      @(posedge clk);
      frame_byte <= b;
      frame_ok   <= ok;
      frame_seen <= 1'b1;
      frame_cnt  <= frame_cnt + 1;
      @(posedge clk);
      frame_seen <= 1'b0;
      if (wr_next) begin
        regs[wr_addr] = b;
        wr_next       = 1'b0;
      end else if (b[7]) begin
        // a read header is answered after a random gap
        delay_bits = 1 + ($unsigned($random(seed)) % 20);
        repeat (delay_bits * `UART_CLKS_PER_BIT) @(posedge clk);
        send_frame(regs[b[6:0]], inject_bad_parity);
      end else begin
        wr_next = 1'b1;
        wr_addr = b[6:0];
      end
    end
  end

endmodule

// File: verif/uart_cmd_tb.sv
`timescale 1ns/1ns
`include "uart_cmd_cfg.svh"

module uart_cmd_tb
  import uart_cmd_pkg::*;
();

  localparam int clk_period   = 100;
  localparam int write_cycles = 22 * `UART_CLKS_PER_BIT + 3;
  localparam int max_cmds     = 40;
  localparam int bits_per_cmd = 40;

  logic        clk = 1'b0;
  logic        rst_n;
  cmd_word_u   cmd_in;
  logic        cmd_vld;
  logic        cmd_rdy;
  logic        tx;
  logic        rx;
  rd_result_t  read_data;
  logic        read_rdy;
  logic        inject_bad_parity;
  logic        frame_seen;
  frame_byte_t frame_byte;
  logic        frame_ok;
  int          frame_cnt;

  integer      seed;
  frame_byte_t shadow [128];
  frame_byte_t exp_frames [$];
  rd_result_t  exp_reads [$];
  logic [6:0]  written [$];
  int          cycle = 0;
  int          accept_cycle = 0;
  logic        write_pending = 1'b0;
  int          n_writes = 0;
  int          n_reads = 0;

  uart_cmd_top uart_cmd_top_inst (
    .clk       (clk),
    .rst_n     (rst_n),
    .cmd_in    (cmd_in),
    .cmd_vld   (cmd_vld),
    .cmd_rdy   (cmd_rdy),
    .rx        (rx),
    .tx        (tx),
    .read_data (read_data),
    .read_rdy  (read_rdy)
  );

  uart_slave_model uart_slave_model_inst (
    .clk               (clk),
    .rst_n             (rst_n),
    .rx                (tx),
    .tx                (rx),
    .inject_bad_parity (inject_bad_parity),
    .frame_seen        (frame_seen),
    .frame_byte        (frame_byte),
    .frame_ok          (frame_ok),
    .frame_cnt         (frame_cnt)
  );

  always #(clk_period / 2) clk = ~clk;

  task automatic stop_with_mismatch(input string msg);
    $display("Mismatch at time %0t: %s", $time, msg);
    $display("Test failed");
    $fatal(1);
  endtask

  task automatic stop_with_error(input string msg);
    $display("Error at time %0t: %s", $time, msg);
    $display("Test failed");
    $fatal(1);
  endtask

  // read result is a one-cycle strobe given while ready again
  assert property (@(posedge clk) disable iff (!rst_n) read_rdy |=> !read_rdy)
    else stop_with_mismatch("read_rdy high for more than one cycle");
  assert property (@(posedge clk) disable iff (!rst_n) read_rdy |-> cmd_rdy)
    else stop_with_mismatch("cmd_rdy low while read_rdy is high");

  // outputs are stable on the falling edge
  always @(negedge clk) begin
    if (rst_n) begin
      cycle = cycle + 1;
      if (write_pending && cmd_rdy) begin
        write_pending = 1'b0;
        assert (cycle - accept_cycle == write_cycles)
          else stop_with_mismatch($sformatf("write busy for %0d cycles, expected %0d",
                                            cycle - accept_cycle, write_cycles));
      end
      if (frame_seen) begin
        assert (exp_frames.size() > 0) else stop_with_error("frame sent with no command pending");
        assert (frame_byte == exp_frames[0])
          else stop_with_mismatch($sformatf("frame byte %h, expected %h",
                                            frame_byte, exp_frames[0]));
        assert (frame_ok) else stop_with_mismatch("frame with bad start, parity or stop bit");
        void'(exp_frames.pop_front());
      end
      if (read_rdy) begin
        assert (exp_reads.size() > 0) else stop_with_error("read result with no read pending");
        assert (read_data.data == exp_reads[0].data)
          else stop_with_mismatch($sformatf("read data %h, expected %h",
                                            read_data.data, exp_reads[0].data));
        assert (read_data.parity_err == exp_reads[0].parity_err)
          else stop_with_mismatch($sformatf("parity_err %b, expected %b",
                                            read_data.parity_err, exp_reads[0].parity_err));
        void'(exp_reads.pop_front());
      end
      // command taken on the next rising edge
      if (cmd_vld && cmd_rdy) begin
        exp_frames.push_back({cmd_in.fields.rw, cmd_in.fields.addr});
        if (cmd_in.fields.rw) begin
          exp_reads.push_back('{data: shadow[cmd_in.fields.addr], parity_err: inject_bad_parity});
          n_reads++;
        end else begin
          exp_frames.push_back(cmd_in.fields.data);
          shadow[cmd_in.fields.addr] = cmd_in.fields.data;
          write_pending = 1'b1;
          accept_cycle  = cycle;
          n_writes++;
        end
      end
    end
  end

  // hold keeps cmd_vld high with junk data while the bridge is busy
  task automatic run_command(input logic rw, input logic [6:0] addr, input frame_byte_t data,
                             input int hold);
    cmd_word_u c;
    c.fields.rw   = rw;
    c.fields.addr = addr;
    c.fields.data = data;
    @(posedge clk);
    cmd_in  <= c;
    cmd_vld <= 1'b1;
    @(negedge clk);
    while (!cmd_rdy) @(negedge clk);
    @(posedge clk);
    cmd_in <= ~c;
    repeat (hold) @(posedge clk);
    cmd_vld <= 1'b0;
    @(negedge clk);
    while (!cmd_rdy) @(negedge clk);
  endtask

  initial begin
    logic [6:0] addr;
    seed              = 32'h38b6;
    rst_n             <= 1'b0;
    cmd_in            <= '0;
    cmd_vld           <= 1'b0;
    inject_bad_parity <= 1'b0;
    repeat (5) @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
    assert (tx && cmd_rdy && !read_rdy) else stop_with_mismatch("idle outputs wrong after reset");
    for (int i = 0; i < 8; i++) begin
      addr = 7'($random(seed));
      run_command(1'b0, addr, 8'($random(seed)), (i == 0) ? 40 : 0);
      written.push_back(addr);
    end
    for (int i = 0; i < 8; i++) begin
      run_command(1'b1, written[$unsigned($random(seed)) % 8], 8'($random(seed)), 0);
    end
    // one reply with flipped parity
    @(posedge clk);
    inject_bad_parity <= 1'b1;
    run_command(1'b1, written[0], 8'h00, 20);
    @(posedge clk);
    inject_bad_parity <= 1'b0;
    run_command(1'b1, written[7], 8'h00, 0);
    repeat (4) @(negedge clk);
    assert (n_writes == 8 && n_reads == 10)
      else stop_with_mismatch($sformatf("%0d writes and %0d reads accepted", n_writes, n_reads));
    assert (frame_cnt == 2 * n_writes + n_reads)
      else stop_with_mismatch($sformatf("frame count %0d, expected %0d",
                                        frame_cnt, 2 * n_writes + n_reads));
    assert (exp_frames.size() == 0 && exp_reads.size() == 0)
      else stop_with_error("expected frames or read results never arrived");
    $display("Test passed");
    $finish;
  end

  initial begin
    #(max_cmds * bits_per_cmd * `UART_CLKS_PER_BIT * clk_period);
    stop_with_error("timeout, the bridge stopped making progress");
  end

endmodule

// File: vlog.f
+incdir+logic
logic/uart_cmd_pkg.sv
logic/baud_tick_gen.sv
logic/uart_tx_frame.sv
logic/uart_rx_frame.sv
logic/uart_cmd_ctrl.sv
logic/uart_cmd_top.sv
verif/uart_slave_model.sv
verif/uart_cmd_tb.sv

// File: run.sh
#!/usr/bin/env bash
# build with Verilator, run, then look for the pass line in the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing -f vlog.f --top-module uart_cmd_tb -o uart_cmd_sim \
  && { ./obj_dir/uart_cmd_sim > sim.log 2>&1 || true; } \
  && cat sim.log \
  && grep -qx "Test passed" sim.log \
  && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }
